// File: common/nnFixedPkg.sv
package nnFixedPkg;

	//////////////////////////////
	// Layer size
	//////////////////////////////

	parameter int NUM_INPUTS = 15; // Activations feeding every neuron.
	parameter int NUM_NODES = 4; // Neurons in the layer.
	parameter int NEURON_LATENCY = 3; // Register stages from inputs to a valid result.

	//////////////////////////////
	// Fixed-point words
	//////////////////////////////

	typedef logic signed [15:0] fixed_t; // Two's complement, wraps at 16 bits.

	typedef fixed_t [NUM_INPUTS-1:0] actVector_t;
	typedef fixed_t [NUM_INPUTS-1:0] weightVector_t;
	typedef weightVector_t [NUM_NODES-1:0] weightMatrix_t; // One row per neuron.
	typedef fixed_t [NUM_NODES-1:0] biasVector_t;

	typedef logic [$clog2(NUM_INPUTS)-1:0] inputIndex_t;
	typedef logic [$clog2(NUM_NODES)-1:0] nodeIndex_t;

endpackage

// File: common/nnRegMapPkg.sv
package nnRegMapPkg;

	parameter int ADDR_W = 8;
	parameter int DATA_W = 32;

	typedef logic [ADDR_W-1:0] axiAddr_t;
	typedef logic [DATA_W-1:0] axiData_t;
	typedef logic [1:0] axiResp_t;

	//////////////////////////////
	// Register offsets
	//////////////////////////////

	parameter axiAddr_t CTRL_ADDR = 8'h00;
	parameter axiAddr_t STATUS_ADDR = 8'h04;
	parameter axiAddr_t INPUT_BASE = 8'h40; // One word per activation.
	parameter axiAddr_t OUTPUT_BASE = 8'h80; // One word per neuron result.

	parameter int CTRL_START_BIT = 0;
	parameter int STATUS_DONE_BIT = 0;
	parameter int STATUS_BUSY_BIT = 1;

	parameter axiResp_t RESP_OKAY = 2'b00;
	parameter axiResp_t RESP_SLVERR = 2'b10;

endpackage

// File: verilog/layerController.sv
module layerController
(
	input logic clk,
	input logic reset,
	input nnRegMapPkg::axiAddr_t awaddr,
	input logic awvalid,
	output logic awready,
	input nnRegMapPkg::axiData_t wdata,
	input logic wvalid,
	output logic wready,
	output nnRegMapPkg::axiResp_t bresp,
	output logic bvalid,
	input logic bready,
	input nnRegMapPkg::axiAddr_t araddr,
	input logic arvalid,
	output logic arready,
	output nnRegMapPkg::axiData_t rdata,
	output nnRegMapPkg::axiResp_t rresp,
	output logic rvalid,
	input logic rready,
	output logic writeEnable,
	output nnFixedPkg::inputIndex_t writeIndex,
	output nnFixedPkg::fixed_t writeData,
	output logic capture,
	output nnFixedPkg::nodeIndex_t readIndex,
	input nnFixedPkg::fixed_t readResult
);
	import nnFixedPkg::*;
	import nnRegMapPkg::*;

	typedef enum logic {IDLE, RUNNING} runState_t;

	runState_t state;
	logic [$clog2(NEURON_LATENCY+1)-1:0] latencyCount;
	logic done;
	logic busy;
	logic writeAccept;
	logic readAccept;
	logic startRun;
	logic writeIsInput;
	logic writeMapped;
	logic readIsOutput;
	logic readMapped;
	axiData_t statusWord;
	axiData_t readWord;

	// Word offset of addr within the region that starts at base.
	function automatic axiAddr_t wordOffset(axiAddr_t addr, axiAddr_t base);
		axiAddr_t delta;
		delta = addr - base;
		return delta >> 2;
	endfunction

	function automatic logic inRegion(axiAddr_t addr, axiAddr_t base, int count);
		axiAddr_t delta;
		delta = addr - base;
		return (addr >= base) && (delta[1:0] == 2'b00) && ((delta >> 2) < count);
	endfunction

	function automatic logic isMapped(axiAddr_t addr);
		return (addr == CTRL_ADDR) || (addr == STATUS_ADDR)
			|| inRegion(addr, INPUT_BASE, NUM_INPUTS)
			|| inRegion(addr, OUTPUT_BASE, NUM_NODES);
	endfunction

	//////////////////////////////
	// AXI4-Lite write channel
	//////////////////////////////

	assign writeAccept = awvalid && wvalid && !bvalid; // Address and data taken together.
	assign awready = writeAccept;
	assign wready = writeAccept;
	assign writeIsInput = inRegion(awaddr, INPUT_BASE, NUM_INPUTS);
	assign writeMapped = isMapped(awaddr);

	assign writeEnable = writeAccept && writeIsInput && !busy; // Inputs are frozen during a run.
	assign writeIndex = inputIndex_t'(wordOffset(awaddr, INPUT_BASE));
	assign writeData = fixed_t'(wdata[$bits(fixed_t)-1:0]);
	assign startRun = writeAccept && (awaddr == CTRL_ADDR) && wdata[CTRL_START_BIT] && !busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
		end
		else if (writeAccept)
		begin
			bvalid <= 1'b1;
			bresp <= writeMapped ? RESP_OKAY : RESP_SLVERR;
		end
		else if (bready)
			bvalid <= 1'b0;
	end

	//////////////////////////////
	// AXI4-Lite read channel
	//////////////////////////////

	assign arready = !rvalid;
	assign readAccept = arvalid && arready;
	assign readIsOutput = inRegion(araddr, OUTPUT_BASE, NUM_NODES);
	assign readMapped = isMapped(araddr);
	assign readIndex = nodeIndex_t'(wordOffset(araddr, OUTPUT_BASE));

	always_comb
	begin
		statusWord = '0;
		statusWord[STATUS_DONE_BIT] = done;
		statusWord[STATUS_BUSY_BIT] = busy;
		if (araddr == STATUS_ADDR)
			readWord = statusWord;
		else if (readIsOutput)
			readWord = {{(DATA_W - $bits(fixed_t)){1'b0}}, readResult}; // Zero-extended.
		else
			readWord = '0; // Control and input registers read back as zero.
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rvalid <= 1'b0;
			rdata <= '0;
			rresp <= RESP_OKAY;
		end
		else if (readAccept)
		begin
			rvalid <= 1'b1;
			rdata <= readWord;
			rresp <= readMapped ? RESP_OKAY : RESP_SLVERR;
		end
		else if (rready)
			rvalid <= 1'b0;
	end

	//////////////////////////////
	// Run sequencing
	//////////////////////////////

	assign busy = (state == RUNNING);
	assign capture = busy && (latencyCount == NEURON_LATENCY - 1); // Bank samples at T+3.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			latencyCount <= '0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (startRun)
					begin
						state <= RUNNING;
						latencyCount <= '0;
						done <= 1'b0;
					end
				RUNNING:
					if (capture)
					begin
						state <= IDLE;
						done <= 1'b1;
					end
					else
						latencyCount <= latencyCount + 1'b1;
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

// File: verilog/activationBuffer.sv
module activationBuffer
(
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input nnFixedPkg::inputIndex_t writeIndex,
	input nnFixedPkg::fixed_t writeData,
	output nnFixedPkg::actVector_t activations
);
	import nnFixedPkg::*;

	//////////////////////////////
	// Activation registers
	//////////////////////////////

	// All neurons read the same vector; it only changes on a host write.
	always_ff @(posedge clk)
	begin
		if (reset)
			activations <= '0;
		else if (writeEnable && (writeIndex < NUM_INPUTS))
			activations[writeIndex] <= writeData; // One word per write.
	end

endmodule

// File: neuron/reluNeuron.sv
module reluNeuron
#(
	parameter nnFixedPkg::weightVector_t WEIGHTS = '0,
	parameter nnFixedPkg::fixed_t BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input nnFixedPkg::actVector_t activations,
	output nnFixedPkg::fixed_t nodeOut
);
	import nnFixedPkg::*;

	actVector_t actReg;
	fixed_t sumReg;
	fixed_t macSum;

	//////////////////////////////
	// Multiply-accumulate
	//////////////////////////////

	// Every product and partial sum is cut to 16 bits, so overflow wraps.
	always_comb
	begin
		macSum = BIAS;
		for (int i = 0; i < NUM_INPUTS; i++)
			macSum = fixed_t'(macSum + actReg[i] * WEIGHTS[i]);
	end

	//////////////////////////////
	// Pipeline stages
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			nodeOut <= '0;
		end
		else
		begin
			actReg <= activations; // Stage 1.
			sumReg <= macSum; // Stage 2.
			if (sumReg[$bits(fixed_t)-1] == 1'b0)
				nodeOut <= sumReg; // Stage 3 passes positive sums.
			else
				nodeOut <= '0; // ReLU clamps negatives.
		end
	end

endmodule

// File: verilog/resultBank.sv
module resultBank
(
	input logic clk,
	input logic reset,
	input logic capture,
	input nnFixedPkg::nodeIndex_t readIndex,
	input nnFixedPkg::fixed_t [nnFixedPkg::NUM_NODES-1:0] nodeOuts,
	output nnFixedPkg::fixed_t readResult
);
	import nnFixedPkg::*;

	fixed_t [NUM_NODES-1:0] snapshot;

	//////////////////////////////
	// Snapshot of the layer
	//////////////////////////////

	// Held between runs so that new inputs do not disturb host reads.
	always_ff @(posedge clk)
	begin
		if (reset)
			snapshot <= '0;
		else if (capture)
			snapshot <= nodeOuts;
	end

	always_comb
	begin
		if (readIndex < NUM_NODES)
			readResult = snapshot[readIndex];
		else
			readResult = '0;
	end

endmodule

// File: verilog/nnLayerTop.sv
module nnLayerTop
#(
	parameter nnFixedPkg::weightMatrix_t LAYER_WEIGHTS = '{
		0: '{0: 31, 1: -3, 2: -4, 3: -5, 4: 11, 5: 15, 6: 10, 7: 9,
			8: 7, 9: -5, 10: -20, 11: -21, 12: -4, 13: -20, 14: -8},
		1: '{0: -12, 1: 8, 2: 14, 3: -2, 4: 6, 5: -9, 6: 3, 7: 17,
			8: -11, 9: 4, 10: 2, 11: -7, 12: 19, 13: -1, 14: 5},
		2: '{0: 5, 1: 5, 2: -18, 3: 22, 4: -3, 5: 0, 6: -14, 7: 6,
			8: 12, 9: -25, 10: 8, 11: 1, 12: -6, 13: 9, 14: 13},
		3: '{0: -7, 1: -16, 2: 9, 3: 4, 4: -1, 5: 20, 6: -8, 7: -13,
			8: 2, 9: 11, 10: -4, 11: 16, 12: 7, 13: -10, 14: 3}
	},
	parameter nnFixedPkg::biasVector_t LAYER_BIASES = '{0: 3, 1: -40, 2: 25, 3: -8}
)
(
	input logic clk,
	input logic reset,
	input nnRegMapPkg::axiAddr_t awaddr,
	input logic awvalid,
	output logic awready,
	input nnRegMapPkg::axiData_t wdata,
	input logic wvalid,
	output logic wready,
	output nnRegMapPkg::axiResp_t bresp,
	output logic bvalid,
	input logic bready,
	input nnRegMapPkg::axiAddr_t araddr,
	input logic arvalid,
	output logic arready,
	output nnRegMapPkg::axiData_t rdata,
	output nnRegMapPkg::axiResp_t rresp,
	output logic rvalid,
	input logic rready
);
	import nnFixedPkg::*;

	logic writeEnable;
	inputIndex_t writeIndex;
	fixed_t writeData;
	logic capture;
	nodeIndex_t readIndex;
	fixed_t readResult;
	actVector_t activations;
	fixed_t [NUM_NODES-1:0] nodeOuts;

	layerController uController
	(
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData),
		.capture(capture), .readIndex(readIndex), .readResult(readResult)
	);

	activationBuffer uBuffer
	(
		.clk(clk), .reset(reset),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData),
		.activations(activations)
	);

	for (genvar n = 0; n < NUM_NODES; n = n + 1)
	begin : gNode
		reluNeuron #(.WEIGHTS(LAYER_WEIGHTS[n]), .BIAS(LAYER_BIASES[n])) uNeuron
		(
			.clk(clk), .reset(reset), .activations(activations), .nodeOut(nodeOuts[n])
		);
	end

	resultBank uResults
	(
		.clk(clk), .reset(reset), .capture(capture),
		.readIndex(readIndex), .nodeOuts(nodeOuts), .readResult(readResult)
	);

endmodule

// File: verif/nnLayerTb.sv
module nnLayerTb;
	timeunit 1ns;
	timeprecision 100ps;

	import nnFixedPkg::*;
	import nnRegMapPkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int NUM_ENTRIES = 6;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (20 * 8 + NEURON_LATENCY) + RESET_CYCLES;

	localparam weightMatrix_t TB_WEIGHTS = '{
		0: '{0: 31, 1: -3, 2: -4, 3: -5, 4: 11, 5: 15, 6: 10, 7: 9,
			8: 7, 9: -5, 10: -20, 11: -21, 12: -4, 13: -20, 14: -8},
		1: '{0: 9, 1: -2, 2: 6, 3: 13, 4: -17, 5: 4, 6: 1, 7: -8,
			8: 22, 9: 3, 10: -6, 11: 10, 12: -15, 13: 7, 14: 2},
		2: '{0: -4, 1: 12, 2: -9, 3: 18, 4: 5, 5: -11, 6: 16, 7: 0,
			8: -3, 9: 8, 10: 14, 11: -19, 12: 6, 13: 1, 14: -12},
		3: '{0: 2, 1: 7, 2: 21, 3: -14, 4: 3, 5: 9, 6: -5, 7: 11,
			8: -16, 9: -2, 10: 4, 11: 8, 12: -7, 13: 15, 14: 6}
	};
	localparam biasVector_t TB_BIASES = '{0: 3, 1: -50, 2: 12, 3: 7};

	logic clk;
	logic reset;
	axiAddr_t awaddr;
	logic awvalid;
	logic awready;
	axiData_t wdata;
	logic wvalid;
	logic wready;
	axiResp_t bresp;
	logic bvalid;
	logic bready;
	axiAddr_t araddr;
	logic arvalid;
	logic arready;
	axiData_t rdata;
	axiResp_t rresp;
	logic rvalid;
	logic rready;

	actVector_t stimTable [NUM_ENTRIES];
	fixed_t expectTable [NUM_ENTRIES][NUM_NODES];
	int valueErrors = 0;
	int protocolErrors = 0;
	int cycleCount = 0;
	integer seed = 32'h2658_97da;

	nnLayerTop #(.LAYER_WEIGHTS(TB_WEIGHTS), .LAYER_BIASES(TB_BIASES)) DUT
	(
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model and checks
	//////////////////////////////

	// Full-width sum, then only the low 16 bits count.
	function automatic fixed_t modelNode(int node, actVector_t acts);
		logic signed [31:0] total;
		total = TB_BIASES[node];
		for (int i = 0; i < NUM_INPUTS; i++)
			total = total + acts[i] * TB_WEIGHTS[node][i];
		return total[15] ? fixed_t'(0) : fixed_t'(total[15:0]); // ReLU.
	endfunction

	task automatic compareWord(input string name, input axiData_t expected, input axiData_t actual);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	//////////////////////////////
	// AXI4-Lite host
	//////////////////////////////

	// Called on a rising edge. Handshakes are sampled on the falling edge.
	task automatic writeRegister(input axiAddr_t addr, input axiData_t data,
		input axiResp_t expResp, input int hold);
		axiResp_t resp;
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= (hold == 0);
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		if (!wready)
		begin
			protocolErrors++;
			$display("wready was low while awready was high at %h", addr);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		compareWord($sformatf("bresp at %h", addr), expResp, resp);
		for (int k = 0; k < hold; k++)
		begin
			@(negedge clk);
			if (!bvalid || bresp !== resp)
			begin
				protocolErrors++;
				$display("Write response at %h changed while bready was low", addr);
			end
		end
		if (hold > 0)
		begin
			@(posedge clk);
			bready <= 1'b1;
		end
		@(posedge clk);
	endtask

	task automatic readRegister(input axiAddr_t addr, input axiResp_t expResp,
		input int hold, output axiData_t data);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= (hold == 0);
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		compareWord($sformatf("rresp at %h", addr), expResp, rresp);
		for (int k = 0; k < hold; k++)
		begin
			@(negedge clk);
			if (!rvalid || rdata !== data)
			begin
				protocolErrors++;
				$display("Read response at %h changed while rready was low", addr);
			end
		end
		if (hold > 0)
		begin
			@(posedge clk);
			rready <= 1'b1;
		end
		@(posedge clk);
	endtask

	task automatic checkResults(input int entry);
		axiData_t word;
		for (int n = 0; n < NUM_NODES; n++)
		begin
			readRegister(axiAddr_t'(OUTPUT_BASE + 4 * n), RESP_OKAY, 0, word);
			compareWord($sformatf("rdata result %0d, entry %0d", n, entry),
				{16'h0000, expectTable[entry][n]}, word);
		end
	endtask

	task automatic applyEntry(input int entry);
		axiData_t word;
		for (int i = 0; i < NUM_INPUTS; i++)
			writeRegister(axiAddr_t'(INPUT_BASE + 4 * i), {16'h0000, stimTable[entry][i]},
				RESP_OKAY, 0);
		writeRegister(CTRL_ADDR, 32'h1, RESP_OKAY, 0);
		readRegister(STATUS_ADDR, RESP_OKAY, 0, word);
		compareWord("STATUS done after start", 32'h0, {31'h0, word[STATUS_DONE_BIT]});
		do
			readRegister(STATUS_ADDR, RESP_OKAY, 0, word);
		while (!word[STATUS_DONE_BIT]);
		checkResults(entry);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		axiData_t word;
		logic [31:0] randWord;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			randWord = $random(seed);
			stimTable[0][i] = '0;
			stimTable[1][i] = fixed_t'(i + 1);
			stimTable[2][i] = (i % 2) ? fixed_t'(-3 * i) : fixed_t'(5 * i);
			stimTable[3][i] = -TB_WEIGHTS[0][i]; // Drives node 0 below zero.
			stimTable[4][i] = (i % 2) ? 16'sh8000 : 16'sh7fff; // Products wrap.
			stimTable[5][i] = randWord[15:0];
		end
		for (int e = 0; e < NUM_ENTRIES; e++)
			for (int n = 0; n < NUM_NODES; n++)
				expectTable[e][n] = modelNode(n, stimTable[e]);
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		readRegister(STATUS_ADDR, RESP_OKAY, 0, word);
		compareWord("STATUS after reset", 32'h0, word);
		for (int e = 0; e < NUM_ENTRIES; e++)
			applyEntry(e);

		for (int i = 0; i < 3; i++)
			writeRegister(axiAddr_t'(INPUT_BASE + 4 * i), 32'h0000_0100, RESP_OKAY, 0);
		checkResults(NUM_ENTRIES - 1); // Snapshot ignores the new inputs.

		writeRegister(INPUT_BASE, 32'h0000_0042, RESP_OKAY, 4);
		readRegister(OUTPUT_BASE, RESP_OKAY, 4, word);
		compareWord("rdata held result 0", {16'h0000, expectTable[NUM_ENTRIES - 1][0]}, word);

		writeRegister(8'h10, 32'h1, RESP_SLVERR, 0);
		writeRegister(8'h42, 32'h1, RESP_SLVERR, 0);
		readRegister(8'h10, RESP_SLVERR, 0, word);
		compareWord("rdata unmapped 10", 32'h0, word);
		readRegister(8'h90, RESP_SLVERR, 0, word);
		compareWord("rdata unmapped 90", 32'h0, word);
		readRegister(STATUS_ADDR, RESP_OKAY, 0, word);
		compareWord("STATUS after unmapped writes", 32'h1, word);

		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors + protocolErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: nnLayer.f
common/nnFixedPkg.sv
common/nnRegMapPkg.sv
verilog/layerController.sv
verilog/activationBuffer.sv
neuron/reluNeuron.sv
verilog/resultBank.sv
verilog/nnLayerTop.sv
verif/nnLayerTb.sv
